//--- hw/mem_pkg.sv
/* Shared sizes, opcode and controller state enums, client request struct
   and queue/FIFO sizing for the line-bridge memory controller */
`default_nettype none

package mem_pkg;

	// Client word and cache line geometry
	localparam int word_bits = 32;
	localparam int words_per_line = 4;
	localparam int line_bits = word_bits * words_per_line;
	// Indexes one word of a line
	localparam int fill_bits = 2;
	// Host line address width
	localparam int addr_bits = 17;

	// Write word FIFO sizing
	localparam int wfifo_depth = 8;
	localparam int wfifo_ptr_bits = 3;
	// Count must reach wfifo_depth itself
	localparam int wfifo_cnt_bits = 4;

	// Request queue sizing
	localparam int rq_depth = 4;
	localparam int rq_ptr_bits = 2;
	localparam int rq_cnt_bits = 3;

	// Client opcodes, value 2 is unused
	typedef enum logic [1:0] {
		op_idle = 2'b00,
		op_read = 2'b01,
		op_write = 2'b11
	} mem_op_e;

	// Controller core states
	typedef enum logic [1:0] {
		st_startup = 2'b00,
		st_ready = 2'b01,
		st_hostop = 2'b10,
		st_fill = 2'b11
	} ctrl_state_e;

	// Client request as it moves through the queue
	typedef struct packed {
		mem_op_e op;
		logic [addr_bits-1:0] addr;
	} mem_req_t;

endpackage

`default_nettype wire

//--- hw/wdata_fifo.sv
/* Write word FIFO between the client data stream and the controller core,
   circular buffer with an occupancy count used to launch writes */
`timescale 1ns/100ps
`default_nettype none

module wdata_fifo import mem_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic [word_bits-1:0] wdata,
	input  logic wdata_valid,
	output logic wdata_ready,
	input  logic pop,
	output logic [word_bits-1:0] head,
	output logic [wfifo_cnt_bits-1:0] count
);

	// Word storage
	logic [word_bits-1:0] mem [wfifo_depth];
	logic [wfifo_ptr_bits-1:0] wr_ptr;
	logic [wfifo_ptr_bits-1:0] rd_ptr;
	logic push;

	// Accept words until every slot is taken
	assign wdata_ready = (count != wfifo_cnt_bits'(wfifo_depth));
	assign push = wdata_valid && wdata_ready;
	// Core sees the oldest word directly
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Core must only pop words the queue said were there
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> (count != '0));

endmodule

`default_nettype wire

//--- hw/req_queue.sv
/* Four entry client request queue, presents the head request to the core
   once it can run and holds it there until the transaction completes */
`timescale 1ns/100ps
`default_nettype none

module req_queue import mem_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  mem_req_t req,
	input  logic req_valid,
	output logic req_ready,
	input  logic [wfifo_cnt_bits-1:0] wdata_count,
	input  logic tx_done,
	output mem_op_e cur_op,
	output logic [addr_bits-1:0] cur_addr
);

	mem_req_t q [rq_depth];
	logic [rq_ptr_bits-1:0] wr_ptr;
	logic [rq_ptr_bits-1:0] rd_ptr;
	logic [rq_cnt_bits-1:0] cnt;
	// Head has been shown to the core and is in flight
	logic launched;
	logic accept;
	logic push;
	logic can_run;
	mem_req_t head_req;

	assign req_ready = (cnt != rq_cnt_bits'(rq_depth));
	assign accept = req_valid && req_ready;
	// Idle or undefined ops are taken off the port but never queued
	assign push = accept && (req.op == op_read || req.op == op_write);
	assign head_req = q[rd_ptr];

	// Reads go at once, writes wait for a full line of data
	always_comb begin
		can_run = 1'b0;
		if (cnt != '0) begin
			if (head_req.op == op_read) begin
				can_run = 1'b1;
			end else if (head_req.op == op_write) begin
				can_run = (wdata_count >= wfifo_cnt_bits'(words_per_line));
			end
		end
	end

	// Hold the head op steady while the core works on it
	assign cur_op = (launched || can_run) ? head_req.op : op_idle;
	assign cur_addr = head_req.addr;

	always_ff @(posedge clk) begin
		if (push) begin
			q[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
			launched <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Completed head leaves the queue
			if (tx_done) begin
				rd_ptr <= rd_ptr + 1'b1;
				launched <= 1'b0;
			end else if (can_run) begin
				launched <= 1'b1;
			end
			case ({push, tx_done})
				2'b10: cnt <= cnt + 1'b1;
				2'b01: cnt <= cnt - 1'b1;
				default: cnt <= cnt;
			endcase
		end
	end

	// Op seen by the core must not move mid transaction
	a_op_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(cur_op != op_idle && !tx_done) |=> (cur_op == $past(cur_op)));

endmodule

`default_nettype wire

//--- hw/mem_ctrl.sv
/* Controller core with startup, ready, fill and host-op state machine,
   128 bit line buffer, write bubble cycle and host address correction */
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl import mem_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic host_init,
	input  logic host_rd_ready,
	input  logic host_wr_ready,
	input  mem_op_e op,
	input  logic [addr_bits-1:0] raw_addr,
	input  logic [addr_bits-1:0] addr_offset,
	input  logic [word_bits-1:0] wdata_head,
	output logic wdata_pop,
	output logic [word_bits-1:0] rdata,
	output logic rd_valid,
	output logic tx_done,
	output logic ctrl_ready,
	input  logic [line_bits-1:0] host_rd_line,
	output logic [line_bits-1:0] host_wr_line,
	output logic [addr_bits-1:0] host_addr,
	output logic host_rgo,
	output logic host_wgo,
	output logic host_re,
	output logic host_we
);

	ctrl_state_e state;
	// Word index for both fill directions
	logic [fill_bits-1:0] fill_cnt;
	// Line buffer, word 0 sits at the low end
	logic [words_per_line-1:0][word_bits-1:0] line_buf;
	// Set after the first host-op cycle of a write
	logic bubble;

	assign host_wr_line = line_buf;
	assign rdata = line_buf[fill_cnt];
	// Wraps at addr_bits
	assign host_addr = raw_addr + addr_offset;

	// Output decode
	always_comb begin
		ctrl_ready = (state != st_startup);
		wdata_pop = 1'b0;
		rd_valid = 1'b0;
		tx_done = 1'b0;
		host_rgo = 1'b0;
		host_wgo = 1'b0;
		host_re = 1'b0;
		host_we = 1'b0;
		case (state)
			st_hostop: begin
				if (op == op_write) begin
					// Go stays up through the bubble
					host_wgo = 1'b1;
					if (bubble && host_wr_ready) begin
						host_we = 1'b1;
						tx_done = 1'b1;
					end
				end else if (op == op_read) begin
					host_rgo = 1'b1;
					// Ack the line as it is captured
					if (host_rd_ready) begin
						host_re = 1'b1;
					end
				end
			end
			st_fill: begin
				if (op == op_write) begin
					wdata_pop = 1'b1;
				end else if (op == op_read) begin
					rd_valid = 1'b1;
					// Last word closes the read
					if (&fill_cnt) begin
						tx_done = 1'b1;
					end
				end
			end
			default: begin
			end
		endcase
	end

	// Sequencing
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_startup;
			fill_cnt <= '0;
			bubble <= 1'b0;
		end else begin
			case (state)
				st_startup: begin
					// Wait for the host DMA to come up
					if (host_init) begin
						state <= st_ready;
					end
				end
				st_ready: begin
					if (op == op_read) begin
						state <= st_hostop;
					end else if (op == op_write) begin
						state <= st_fill;
					end
				end
				st_fill: begin
					fill_cnt <= fill_cnt + 1'b1;
					// Counter wraps back to 0 on the last word
					if (&fill_cnt) begin
						state <= (op == op_write) ? st_hostop : st_ready;
					end
				end
				st_hostop: begin
					if (op == op_read) begin
						if (host_rd_ready) begin
							state <= st_fill;
						end
					end else if (op == op_write) begin
						// One idle cycle lets host_addr settle
						if (!bubble) begin
							bubble <= 1'b1;
						end else if (host_wr_ready) begin
							bubble <= 1'b0;
							state <= st_ready;
						end
					end else begin
						state <= st_ready;
					end
				end
				default: state <= st_startup;
			endcase
		end
	end

	// Writes shift in from the top, reads load the whole line
	always_ff @(posedge clk) begin
		if (wdata_pop) begin
			line_buf <= {wdata_head, line_buf[words_per_line-1:1]};
		end else if (host_re) begin
			line_buf <= host_rd_line;
		end
	end

	// Host handshakes are mutually exclusive
	a_re_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(host_we && host_re));

	// Write strobe only after a go cycle, the bubble
	a_we_after_go: assert property (@(posedge clk) disable iff (!rst_n)
		host_we |-> $past(host_wgo));

	// Read words follow a captured line
	a_rd_valid_fill: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> (state == st_fill) && ($past(host_re) || $past(rd_valid)));

endmodule

`default_nettype wire

//--- hw/mem_ctrl_top.sv
/* Top level of the line bridge, request queue and write word FIFO
   feeding the controller core, client and host ports */
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_top import mem_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	// Client request port
	input  mem_req_t req,
	input  logic req_valid,
	output logic req_ready,
	// Client write data stream
	input  logic [word_bits-1:0] wdata,
	input  logic wdata_valid,
	output logic wdata_ready,
	// Read data, no back-pressure
	output logic [word_bits-1:0] rdata,
	output logic rd_valid,
	output logic tx_done,
	output logic ctrl_ready,
	input  logic [addr_bits-1:0] addr_offset,
	// Host DMA channel
	input  logic host_init,
	input  logic host_rd_ready,
	input  logic host_wr_ready,
	input  logic [line_bits-1:0] host_rd_line,
	output logic [line_bits-1:0] host_wr_line,
	output logic [addr_bits-1:0] host_addr,
	output logic host_rgo,
	output logic host_wgo,
	output logic host_re,
	output logic host_we
);

	// Queue and FIFO to core
	mem_op_e cur_op;
	logic [addr_bits-1:0] cur_addr;
	logic [word_bits-1:0] wdata_head;
	logic [wfifo_cnt_bits-1:0] wdata_count;
	logic wdata_pop;

	req_queue u_req_queue (
		.clk(clk), .rst_n(rst_n),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.wdata_count(wdata_count), .tx_done(tx_done),
		.cur_op(cur_op), .cur_addr(cur_addr)
	);

	wdata_fifo u_wdata_fifo (
		.clk(clk), .rst_n(rst_n),
		.wdata(wdata), .wdata_valid(wdata_valid), .wdata_ready(wdata_ready),
		.pop(wdata_pop), .head(wdata_head), .count(wdata_count)
	);

	mem_ctrl u_mem_ctrl (
		.clk(clk), .rst_n(rst_n),
		.host_init(host_init), .host_rd_ready(host_rd_ready), .host_wr_ready(host_wr_ready),
		.op(cur_op), .raw_addr(cur_addr), .addr_offset(addr_offset),
		.wdata_head(wdata_head), .wdata_pop(wdata_pop),
		.rdata(rdata), .rd_valid(rd_valid), .tx_done(tx_done), .ctrl_ready(ctrl_ready),
		.host_rd_line(host_rd_line), .host_wr_line(host_wr_line), .host_addr(host_addr),
		.host_rgo(host_rgo), .host_wgo(host_wgo), .host_re(host_re), .host_we(host_we)
	);

endmodule

`default_nettype wire

//--- bench/host_dma_model.sv
/* Host DMA stand-in with preset line memory, a one-cycle init pulse
   after reset and read/write ready stalled by supplied random bits */
`timescale 1ns/100ps
`default_nettype none

module host_dma_model import mem_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic rd_stall,
	input  logic wr_stall,
	input  logic host_rgo,
	input  logic host_wgo,
	input  logic host_re,
	input  logic host_we,
	input  logic [addr_bits-1:0] host_addr,
	input  logic [line_bits-1:0] host_wr_line,
	output logic host_init,
	output logic host_rd_ready,
	output logic host_wr_ready,
	output logic [line_bits-1:0] host_rd_line
);

	// One line per host address
	logic [line_bits-1:0] mem [0:(1<<addr_bits)-1];
	// Cycles since reset, saturates
	logic [5:0] init_cnt;

	// Preset contents, every word depends on the full line address
	function automatic logic [line_bits-1:0] preset_line(input int a);
		logic [line_bits-1:0] l;
		for (int w = 0; w < words_per_line; w++) begin
			l[w*word_bits +: word_bits] = (32'(a) * 32'h9E37_79B1) + 32'(w) * 32'h0101_0101;
		end
		return l;
	endfunction

	initial begin
		for (int a = 0; a < (1 << addr_bits); a++) begin
			mem[a] = preset_line(a);
		end
	end

	// Ready follows go unless the bench stalls it
	assign host_rd_ready = host_rgo && !rd_stall;
	assign host_wr_ready = host_wgo && !wr_stall;
	assign host_rd_line = mem[host_addr];

	// Line lands only on the write strobe
	always @(posedge clk) begin
		if (host_we) begin
			mem[host_addr] <= host_wr_line;
		end
	end

	// Init pulse some 30 cycles after reset release
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			init_cnt <= '0;
			host_init <= 1'b0;
		end else begin
			host_init <= (init_cnt == 6'd29);
			if (init_cnt != 6'd63) begin
				init_cnt <= init_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/mem_ctrl_tb.sv
/* Testbench for mem_ctrl_top with host DMA model, LFSR stimulus,
   request/word reference queues, shadow line memory and checks */
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_tb import mem_pkg::*; ();

	logic clk;
	logic rst_n;
	mem_req_t req;
	logic req_valid;
	logic req_ready;
	logic [word_bits-1:0] wdata;
	logic wdata_valid;
	logic wdata_ready;
	logic [word_bits-1:0] rdata;
	logic rd_valid;
	logic tx_done;
	logic ctrl_ready;
	logic [addr_bits-1:0] addr_offset;
	logic host_init;
	logic host_rd_ready;
	logic host_wr_ready;
	logic [line_bits-1:0] host_rd_line;
	logic [line_bits-1:0] host_wr_line;
	logic [addr_bits-1:0] host_addr;
	logic host_rgo;
	logic host_wgo;
	logic host_re;
	logic host_we;
	logic rd_stall;
	logic wr_stall;

	// LFSR state and pre-generated stimulus
	logic [31:0] lfsr;
	mem_req_t rq_list[$];
	int rq_gap[$];
	logic [word_bits-1:0] wd_list[$];
	int wd_gap[$];
	logic [word_bits-1:0] dir_words[$];
	logic [addr_bits-1:0] dir_addr [4];

	// Reference model
	mem_req_t acc_q[$];
	logic [word_bits-1:0] word_q[$];
	logic [line_bits-1:0] shadow [0:(1<<addr_bits)-1];

	string test_name;
	int err_cnt;
	int chk_cnt;
	int done_cnt;
	int wgo_cnt;
	int re_cnt;
	int rd_idx;
	bit init_seen;
	bit wr_pending;
	logic [addr_bits-1:0] wr_pend_addr;

	mem_ctrl_top UUT (
		.clk(clk), .rst_n(rst_n),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.wdata(wdata), .wdata_valid(wdata_valid), .wdata_ready(wdata_ready),
		.rdata(rdata), .rd_valid(rd_valid), .tx_done(tx_done), .ctrl_ready(ctrl_ready),
		.addr_offset(addr_offset),
		.host_init(host_init), .host_rd_ready(host_rd_ready), .host_wr_ready(host_wr_ready),
		.host_rd_line(host_rd_line), .host_wr_line(host_wr_line), .host_addr(host_addr),
		.host_rgo(host_rgo), .host_wgo(host_wgo), .host_re(host_re), .host_we(host_we)
	);

	host_dma_model host (
		.clk(clk), .rst_n(rst_n), .rd_stall(rd_stall), .wr_stall(wr_stall),
		.host_rgo(host_rgo), .host_wgo(host_wgo), .host_re(host_re), .host_we(host_we),
		.host_addr(host_addr), .host_wr_line(host_wr_line),
		.host_init(host_init), .host_rd_ready(host_rd_ready), .host_wr_ready(host_wr_ready),
		.host_rd_line(host_rd_line)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Same preset contents as the host model
	function automatic logic [line_bits-1:0] initial_line(input int a);
		logic [line_bits-1:0] l;
		for (int w = 0; w < words_per_line; w++) begin
			l[w*word_bits +: word_bits] = (32'(a) * 32'h9E37_79B1) + 32'(w) * 32'h0101_0101;
		end
		return l;
	endfunction

	initial begin
		for (int a = 0; a < (1 << addr_bits); a++) begin
			shadow[a] = initial_line(a);
		end
	end

	task automatic flag_mismatch(input string what, input logic [line_bits-1:0] exp_v,
		input logic [line_bits-1:0] act_v);
		$display("ERROR %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
		err_cnt++;
	endtask

	task automatic flag_failure(input string why);
		$display("%s in test %s", why, test_name);
		err_cnt++;
	endtask

	// Closing report and end of the run
	task automatic finish_run();
		$display("checks %0d transactions %0d errors %0d", chk_cnt, done_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	// All drive tasks start and end 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_req(input mem_req_t r);
		int t;
		req = r;
		req_valid = 1'b1;
		t = 0;
		@(negedge clk);
		while (!req_ready && t < 500) begin
			@(negedge clk);
			t++;
		end
		if (!req_ready) begin
			flag_failure("Request port never became ready");
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic send_word(input logic [word_bits-1:0] w);
		int t;
		wdata = w;
		wdata_valid = 1'b1;
		t = 0;
		@(negedge clk);
		while (!wdata_ready && t < 500) begin
			@(negedge clk);
			t++;
		end
		if (!wdata_ready) begin
			flag_failure("Write data port never became ready");
		end
		@(posedge clk);
		#1;
		wdata_valid = 1'b0;
	endtask

	task automatic wait_ready();
		int t;
		t = 0;
		while (!ctrl_ready && t < 200) begin
			@(posedge clk);
			#1;
			t++;
		end
		if (!ctrl_ready) begin
			flag_failure("Controller never left startup");
		end
	endtask

	// Every accepted request has completed
	task automatic wait_drain();
		int t;
		t = 0;
		while (acc_q.size() != 0 && t < 3000) begin
			@(posedge clk);
			#1;
			t++;
		end
		if (acc_q.size() != 0) begin
			flag_failure("Outstanding requests never completed");
		end
	endtask

	// Fresh pair of host stall bits each cycle
	always @(posedge clk) begin
		#1;
		rd_stall = (rand_bits(1) != 0);
		wr_stall = (rand_bits(1) != 0);
	end

	// Monitor samples at the falling edge where every signal is settled
	always @(negedge clk) begin : monitor
		mem_req_t hd;
		logic [addr_bits-1:0] ea;
		logic [line_bits-1:0] exp_line;
		if (rst_n) begin
			// Line the host stored on the last edge
			if (wr_pending) begin
				chk_cnt++;
				if (host.mem[wr_pend_addr] !== shadow[wr_pend_addr]) begin
					flag_mismatch("host_line", shadow[wr_pend_addr], host.mem[wr_pend_addr]);
				end
				wr_pending = 1'b0;
			end
			chk_cnt++;
			if (!init_seen) begin
				if (ctrl_ready || host_rgo || host_wgo || tx_done) begin
					flag_failure("Controller active before host_init");
				end
				if (host_init) begin
					init_seen = 1'b1;
				end
			end else if (!ctrl_ready) begin
				flag_failure("ctrl_ready low after host_init");
			end
			hd = (acc_q.size() != 0) ? acc_q[0] : '0;
			// Host address wraps at addr_bits
			ea = hd.addr + addr_offset;
			if (host_wgo) begin
				wgo_cnt++;
				chk_cnt++;
				if (word_q.size() < words_per_line) begin
					flag_failure("Write launched before four data words were pushed");
				end
			end
			if (host_re) begin
				re_cnt++;
				chk_cnt++;
				if (hd.op != op_read || rd_idx != 0) begin
					flag_failure("host_re outside a read");
				end
				if (host_addr !== ea) begin
					flag_mismatch("read_addr", ea, host_addr);
				end
			end
			if (host_we) begin
				chk_cnt++;
				if (hd.op != op_write || word_q.size() < words_per_line || !tx_done) begin
					flag_failure("host_we without a matching write");
				end else begin
					exp_line = {word_q[3], word_q[2], word_q[1], word_q[0]};
					if (host_addr !== ea) begin
						flag_mismatch("write_addr", ea, host_addr);
					end
					if (host_wr_line !== exp_line) begin
						flag_mismatch("write_line", exp_line, host_wr_line);
					end
					// Bubble cycle plus strobe cycle
					if (wgo_cnt < 2) begin
						flag_mismatch("wgo_cycles", 2, wgo_cnt);
					end
				end
			end
			if (rd_valid) begin
				chk_cnt++;
				if (hd.op != op_read || re_cnt != 1) begin
					flag_failure("Read data not preceded by exactly one host_re");
				end
				exp_line = shadow[ea];
				if (rdata !== exp_line[rd_idx*word_bits +: word_bits]) begin
					flag_mismatch("read_word", exp_line[rd_idx*word_bits +: word_bits], rdata);
				end
				rd_idx++;
			end
			if (tx_done) begin
				chk_cnt++;
				if (acc_q.size() == 0) begin
					flag_failure("tx_done with no outstanding request");
				end else begin
					if (hd.op == op_write && word_q.size() >= words_per_line) begin
						shadow[ea] = {word_q[3], word_q[2], word_q[1], word_q[0]};
						repeat (words_per_line) void'(word_q.pop_front());
						wr_pending = 1'b1;
						wr_pend_addr = ea;
					end else if (hd.op == op_read && rd_idx != words_per_line) begin
						flag_mismatch("read_words_at_done", words_per_line, rd_idx);
					end
					void'(acc_q.pop_front());
					done_cnt++;
				end
				rd_idx = 0;
				re_cnt = 0;
				wgo_cnt = 0;
			end
			// Handshakes seen now land on the coming edge
			if (req_valid && req_ready) begin
				acc_q.push_back(req);
			end
			if (wdata_valid && wdata_ready) begin
				word_q.push_back(wdata);
			end
		end
	end

	initial begin : main
		mem_req_t r;
		lfsr = 32'd42;
		test_name = "reset";
		rst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		wdata = '0;
		wdata_valid = 1'b0;
		rd_stall = 1'b0;
		wr_stall = 1'b0;
		err_cnt = 0;
		chk_cnt = 0;
		done_cnt = 0;
		wgo_cnt = 0;
		re_cnt = 0;
		rd_idx = 0;
		init_seen = 1'b0;
		wr_pending = 1'b0;
		wr_pend_addr = '0;
		// All stimulus drawn before the stall process starts
		addr_offset = addr_bits'(rand_bits(addr_bits));
		for (int i = 0; i < 4; i++) begin
			dir_addr[i] = addr_bits'(rand_bits(6));
		end
		for (int i = 0; i < 16; i++) begin
			dir_words.push_back(rand_bits(word_bits));
		end
		for (int i = 0; i < 24; i++) begin
			r.op = (rand_bits(1) != 0) ? op_write : op_read;
			// 64 line window
			r.addr = addr_bits'(rand_bits(6));
			rq_list.push_back(r);
			rq_gap.push_back(int'(rand_bits(2)));
			if (r.op == op_write) begin
				repeat (words_per_line) begin
					wd_list.push_back(rand_bits(word_bits));
					wd_gap.push_back(int'(rand_bits(2)));
				end
			end
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Requests and data queued while the host is still down
		test_name = "pre_init";
		r.op = op_write;
		r.addr = dir_addr[0];
		send_req(r);
		repeat (words_per_line) send_word(dir_words.pop_front());
		r.op = op_read;
		r.addr = dir_addr[0];
		send_req(r);
		wait_ready();
		wait_drain();

		// Write with one word missing holds itself and the read behind it
		test_name = "short_write";
		r.op = op_write;
		r.addr = dir_addr[1];
		send_req(r);
		repeat (3) send_word(dir_words.pop_front());
		r.op = op_read;
		r.addr = dir_addr[2];
		send_req(r);
		idle_cycles(20);
		chk_cnt++;
		if (acc_q.size() != 2) begin
			flag_mismatch("pending_requests", 2, acc_q.size());
		end
		send_word(dir_words.pop_front());
		wait_drain();

		// Two lines of data fill the word FIFO before any write is queued
		test_name = "wfifo_full";
		repeat (wfifo_depth) send_word(dir_words.pop_front());
		chk_cnt++;
		if (wdata_ready !== 1'b0) begin
			flag_mismatch("wdata_ready", 0, wdata_ready);
		end
		r.op = op_write;
		r.addr = dir_addr[3];
		send_req(r);
		send_req(r);
		wait_drain();

		// Request and data streams with random gaps and host stalls
		test_name = "random";
		fork
			begin
				for (int k = 0; k < rq_list.size(); k++) begin
					idle_cycles(rq_gap[k]);
					send_req(rq_list[k]);
				end
			end
			begin
				for (int k = 0; k < wd_list.size(); k++) begin
					idle_cycles(wd_gap[k]);
					send_word(wd_list[k]);
				end
			end
		join
		wait_drain();
		idle_cycles(2);
		chk_cnt++;
		if (word_q.size() != 0) begin
			flag_mismatch("leftover_words", 0, word_q.size());
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- mem_ctrl_top.f
hw/mem_pkg.sv
hw/wdata_fifo.sv
hw/req_queue.sv
hw/mem_ctrl.sv
hw/mem_ctrl_top.sv
bench/host_dma_model.sv
bench/mem_ctrl_tb.sv
